//--- design/slc3_control.sv
// One state per clock with no halt instruction, so once run_i starts the core it only stops at PAUSE
`timescale 1ns/1ps

module slc3_control (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      run_i,
    input  logic                      continue_i,
    input  slc3_isa_pkg::instr_u      instr_i,
    input  logic                      ben_i,
    output slc3_ctrl_pkg::ctrl_word_t ctrl_o,
    output logic                      mem_ena_o,
    output logic                      mem_wr_o
);

    import slc3_isa_pkg::*;
    import slc3_ctrl_pkg::*;

    state_e  state_q;
    state_e  state_nxt;
    opcode_e opcode;

    assign opcode = instr_i.reg_form.opcode;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= S_HALT;
        end else begin
            state_q <= state_nxt;
        end
    end

    // ----------------------------------------
    // Next state and control word
    // ----------------------------------------
    always_comb begin
        ctrl_o    = CTRL_IDLE;
        mem_ena_o = 1'b0;
        mem_wr_o  = 1'b0;
        state_nxt = state_q;

        case (state_q)
            S_HALT: begin
                if (run_i) begin
                    state_nxt = S_FETCH1;
                end
            end

            // MAR <- PC, PC <- PC + 1
            S_FETCH1: begin
                ctrl_o.bus_src = GATE_PC;
                ctrl_o.ld_mar  = 1'b1;
                ctrl_o.ld_pc   = 1'b1;
                ctrl_o.pc_mux  = PC_PLUS1;
                state_nxt      = S_FETCH2;
            end
            S_FETCH2: begin
                mem_ena_o = 1'b1;
                state_nxt = S_FETCH3;
            end
            S_FETCH3: begin
                ctrl_o.ld_mdr       = 1'b1;
                ctrl_o.mdr_from_mem = 1'b1;
                state_nxt           = S_FETCH4;
            end
            S_FETCH4: begin
                ctrl_o.bus_src = GATE_MDR;
                ctrl_o.ld_ir   = 1'b1;
                state_nxt      = S_DECODE;
            end

            S_DECODE: begin
                ctrl_o.ld_ben = 1'b1;
                case (opcode)
                    OP_ADD, OP_AND, OP_NOT: state_nxt = S_ALU;
                    OP_BR:    state_nxt = S_BR;
                    OP_JMP:   state_nxt = S_JMP;
                    OP_JSR:   state_nxt = S_JSR1;
                    OP_LDR:   state_nxt = S_LDR1;
                    OP_STR:   state_nxt = S_STR1;
                    OP_PAUSE: state_nxt = S_PAUSE;
                    default:  state_nxt = S_FETCH1;
                endcase
            end

            // ADD, AND and NOT share one state, only the ALU op differs
            S_ALU: begin
                ctrl_o.bus_src = GATE_ALU;
                ctrl_o.ld_reg  = 1'b1;
                ctrl_o.ld_cc   = 1'b1;
                ctrl_o.dr_sel  = DR_IR;
                ctrl_o.sr1_sel = SR1_BASE;
                ctrl_o.alu_imm = instr_i.reg_form.imm;
                case (opcode)
                    OP_AND:  ctrl_o.alu_op = ALU_AND;
                    OP_NOT:  ctrl_o.alu_op = ALU_NOT;
                    default: ctrl_o.alu_op = ALU_ADD;
                endcase
                state_nxt = S_FETCH1;
            end

            S_BR: begin
                ctrl_o.ld_pc     = ben_i;
                ctrl_o.pc_mux    = PC_ADDER;
                ctrl_o.addr1_sel = ADDR1_PC;
                ctrl_o.addr2_sel = ADDR2_OFF9;
                state_nxt        = S_FETCH1;
            end

            // Base register passes through the ALU onto the bus
            S_JMP: begin
                ctrl_o.bus_src = GATE_ALU;
                ctrl_o.sr1_sel = SR1_BASE;
                ctrl_o.alu_op  = ALU_PASS;
                ctrl_o.ld_pc   = 1'b1;
                ctrl_o.pc_mux  = PC_BUS;
                state_nxt      = S_FETCH1;
            end

            S_JSR1: begin
                ctrl_o.bus_src = GATE_PC;
                ctrl_o.ld_reg  = 1'b1;
                ctrl_o.dr_sel  = DR_R7;
                state_nxt      = S_JSR2;
            end
            S_JSR2: begin
                ctrl_o.ld_pc     = 1'b1;
                ctrl_o.pc_mux    = PC_ADDER;
                ctrl_o.addr1_sel = ADDR1_PC;
                ctrl_o.addr2_sel = ADDR2_OFF11;
                state_nxt        = S_FETCH1;
            end

            // MAR <- base + offset6, same for LDR and STR
            S_LDR1, S_STR1: begin
                ctrl_o.bus_src   = GATE_MARMUX;
                ctrl_o.ld_mar    = 1'b1;
                ctrl_o.sr1_sel   = SR1_BASE;
                ctrl_o.addr1_sel = ADDR1_SR1;
                ctrl_o.addr2_sel = ADDR2_OFF6;
                state_nxt        = (state_q == S_LDR1) ? S_LDR2 : S_STR2;
            end
            S_LDR2: begin
                mem_ena_o = 1'b1;
                state_nxt = S_LDR3;
            end
            S_LDR3: begin
                ctrl_o.ld_mdr       = 1'b1;
                ctrl_o.mdr_from_mem = 1'b1;
                state_nxt           = S_LDR4;
            end
            S_LDR4: begin
                ctrl_o.bus_src = GATE_MDR;
                ctrl_o.ld_reg  = 1'b1;
                ctrl_o.ld_cc   = 1'b1;
                ctrl_o.dr_sel  = DR_IR;
                state_nxt      = S_FETCH1;
            end

            // Source register of STR sits in the dr field
            S_STR2: begin
                ctrl_o.bus_src = GATE_ALU;
                ctrl_o.sr1_sel = SR1_DR;
                ctrl_o.alu_op  = ALU_PASS;
                ctrl_o.ld_mdr  = 1'b1;
                state_nxt      = S_STR3;
            end
            S_STR3: begin
                mem_ena_o = 1'b1;
                mem_wr_o  = 1'b1;
                state_nxt = S_FETCH1;
            end

            S_PAUSE: begin
                ctrl_o.ld_led = 1'b1;
                if (continue_i) begin
                    state_nxt = S_FETCH1;
                end
            end

            default: state_nxt = S_HALT;
        endcase
    end

endmodule

//--- design/slc3_cpu.sv
// Memory must return read data one cycle after mem_ena_o and hex_display_o mirrors IR
`timescale 1ns/1ps

module slc3_cpu #(
    parameter slc3_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                run_i,
    input  logic                continue_i,
    input  slc3_isa_pkg::word_t mem_rdata_i,
    output slc3_isa_pkg::word_t mem_addr_o,
    output slc3_isa_pkg::word_t mem_wdata_o,
    output logic                mem_ena_o,
    output logic                mem_wr_o,
    output logic [11:0]         led_o,
    output slc3_isa_pkg::word_t hex_display_o
);

    import slc3_isa_pkg::*;
    import slc3_ctrl_pkg::*;

    ctrl_word_t ctrl;
    instr_u     instr;
    logic       ben;
    logic [2:0] dr_addr;
    logic [2:0] sr1_addr;
    logic [2:0] sr2_addr;
    logic       reg_wr;
    word_t      bus;
    word_t      sr1_data;
    word_t      sr2_data;

    assign hex_display_o = instr;

    slc3_control control0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .run_i      (run_i),
        .continue_i (continue_i),
        .instr_i    (instr),
        .ben_i      (ben),
        .ctrl_o     (ctrl),
        .mem_ena_o  (mem_ena_o),
        .mem_wr_o   (mem_wr_o)
    );

    slc3_datapath #(
        .RESET_PC (RESET_PC)
    ) datapath0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .ctrl_i      (ctrl),
        .mem_rdata_i (mem_rdata_i),
        .sr1_data_i  (sr1_data),
        .sr2_data_i  (sr2_data),
        .instr_o     (instr),
        .ben_o       (ben),
        .dr_addr_o   (dr_addr),
        .sr1_addr_o  (sr1_addr),
        .sr2_addr_o  (sr2_addr),
        .reg_wr_o    (reg_wr),
        .bus_o       (bus),
        .mar_o       (mem_addr_o),
        .mdr_o       (mem_wdata_o),
        .led_o       (led_o)
    );

    // Bus is the only write data path into the registers
    slc3_reg_file reg_file0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_i       (reg_wr),
        .dr_addr_i  (dr_addr),
        .sr1_addr_i (sr1_addr),
        .sr2_addr_i (sr2_addr),
        .wdata_i    (bus),
        .sr1_data_o (sr1_data),
        .sr2_data_o (sr2_data)
    );

endmodule

//--- design/slc3_ctrl_pkg.sv
// Control word encodings assume a single bus driver per cycle and NONE puts zero on the bus
package slc3_ctrl_pkg;

    // ----------------------------------------
    // Datapath selects
    // ----------------------------------------

    // Zero encoding is the idle bus
    typedef enum logic [2:0] {
        NONE        = 3'd0,
        GATE_PC     = 3'd1,
        GATE_MDR    = 3'd2,
        GATE_ALU    = 3'd3,
        GATE_MARMUX = 3'd4
    } bus_src_e;

    typedef enum logic [1:0] {
        PC_PLUS1 = 2'd0,
        PC_ADDER = 2'd1,
        PC_BUS   = 2'd2
    } pc_mux_e;

    typedef enum logic {ADDR1_PC, ADDR1_SR1} addr1_sel_e;

    typedef enum logic [1:0] {
        ADDR2_ZERO  = 2'd0,
        ADDR2_OFF6  = 2'd1,
        ADDR2_OFF9  = 2'd2,
        ADDR2_OFF11 = 2'd3
    } addr2_sel_e;

    typedef enum logic {DR_IR, DR_R7} dr_sel_e;

    // Base field is IR[8:6], dr field is IR[11:9]
    typedef enum logic {SR1_BASE, SR1_DR} sr1_sel_e;

    typedef enum logic [1:0] {
        ALU_ADD  = 2'd0,
        ALU_AND  = 2'd1,
        ALU_NOT  = 2'd2,
        ALU_PASS = 2'd3
    } alu_op_e;

    // ----------------------------------------
    // Control word, one per state
    // ----------------------------------------
    typedef struct packed {
        logic       ld_mar;
        logic       ld_mdr;
        logic       ld_ir;
        logic       ld_pc;
        logic       ld_reg;
        logic       ld_cc;
        logic       ld_ben;
        logic       ld_led;
        bus_src_e   bus_src;
        pc_mux_e    pc_mux;
        addr1_sel_e addr1_sel;
        addr2_sel_e addr2_sel;
        dr_sel_e    dr_sel;
        sr1_sel_e   sr1_sel;
        alu_op_e    alu_op;
        logic       alu_imm;
        logic       mdr_from_mem;
    } ctrl_word_t;

    // No loads, nothing on the bus
    localparam ctrl_word_t CTRL_IDLE = '0;

    typedef enum logic [4:0] {
        S_HALT,
        S_FETCH1,
        S_FETCH2,
        S_FETCH3,
        S_FETCH4,
        S_DECODE,
        S_ALU,
        S_BR,
        S_JMP,
        S_JSR1,
        S_JSR2,
        S_LDR1,
        S_LDR2,
        S_LDR3,
        S_LDR4,
        S_STR1,
        S_STR2,
        S_STR3,
        S_PAUSE
    } state_e;

endpackage

//--- design/slc3_datapath.sv
// Single 16-bit bus with one driver per cycle and MAR and MDR hold no reset value
`timescale 1ns/1ps

module slc3_datapath #(
    parameter slc3_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      reset_i,
    input  slc3_ctrl_pkg::ctrl_word_t ctrl_i,
    input  slc3_isa_pkg::word_t       mem_rdata_i,
    input  slc3_isa_pkg::word_t       sr1_data_i,
    input  slc3_isa_pkg::word_t       sr2_data_i,
    output slc3_isa_pkg::instr_u      instr_o,
    output logic                      ben_o,
    output logic [2:0]                dr_addr_o,
    output logic [2:0]                sr1_addr_o,
    output logic [2:0]                sr2_addr_o,
    output logic                      reg_wr_o,
    output slc3_isa_pkg::word_t       bus_o,
    output slc3_isa_pkg::word_t       mar_o,
    output slc3_isa_pkg::word_t       mdr_o,
    output logic [11:0]               led_o
);

    import slc3_isa_pkg::*;
    import slc3_ctrl_pkg::*;

    word_t      pc_q;
    word_t      mar_q;
    word_t      mdr_q;
    instr_u     ir_q;
    logic [2:0] nzp_q;
    logic       ben_q;
    logic [11:0] led_q;

    word_t      bus;
    word_t      pc_nxt;
    word_t      mdr_nxt;
    word_t      addr1;
    word_t      addr2;
    word_t      addr_sum;
    word_t      alu_b;
    word_t      alu_out;
    word_t      sext5;
    word_t      sext6;
    word_t      sext9;
    word_t      sext11;
    logic [2:0] nzp_nxt;

    // ----------------------------------------
    // Sign extension of IR fields
    // ----------------------------------------
    assign sext5  = {{11{ir_q.reg_form.unused[1]}}, ir_q.reg_form.unused, ir_q.reg_form.sr2};
    assign sext6  = {{10{ir_q.off_form.offset6[5]}}, ir_q.off_form.offset6};
    assign sext9  = {{7{ir_q.off_form.base[2]}}, ir_q.off_form.base, ir_q.off_form.offset6};
    assign sext11 = {{5{ir_q.off_form.nzp_dr[1]}}, ir_q.off_form.nzp_dr[1:0],
                     ir_q.off_form.base, ir_q.off_form.offset6};

    // Address adder
    assign addr1 = (ctrl_i.addr1_sel == ADDR1_SR1) ? sr1_data_i : pc_q;

    always_comb begin
        case (ctrl_i.addr2_sel)
            ADDR2_OFF6:  addr2 = sext6;
            ADDR2_OFF9:  addr2 = sext9;
            ADDR2_OFF11: addr2 = sext11;
            default:     addr2 = '0;
        endcase
    end

    assign addr_sum = addr1 + addr2;

    // ALU, SR1 is always the A operand
    assign alu_b = ctrl_i.alu_imm ? sext5 : sr2_data_i;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD: alu_out = sr1_data_i + alu_b;
            ALU_AND: alu_out = sr1_data_i & alu_b;
            ALU_NOT: alu_out = ~sr1_data_i;
            default: alu_out = sr1_data_i;
        endcase
    end

    // ----------------------------------------
    // Bus
    // ----------------------------------------
    always_comb begin
        case (ctrl_i.bus_src)
            GATE_PC:     bus = pc_q;
            GATE_MDR:    bus = mdr_q;
            GATE_ALU:    bus = alu_out;
            GATE_MARMUX: bus = addr_sum;
            default:     bus = '0;
        endcase
    end

    always_comb begin
        case (ctrl_i.pc_mux)
            PC_ADDER: pc_nxt = addr_sum;
            PC_BUS:   pc_nxt = bus;
            default:  pc_nxt = pc_q + 16'd1;
        endcase
    end

    assign mdr_nxt = ctrl_i.mdr_from_mem ? mem_rdata_i : bus;

    // n, z, p taken from whatever is on the bus
    assign nzp_nxt = {bus[15], bus == '0, ~bus[15] & (bus != '0)};

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q  <= RESET_PC;
            ir_q  <= '0;
            nzp_q <= '0;
            ben_q <= 1'b0;
            led_q <= '0;
        end else begin
            if (ctrl_i.ld_pc) begin
                pc_q <= pc_nxt;
            end
            if (ctrl_i.ld_ir) begin
                ir_q <= bus;
            end
            if (ctrl_i.ld_cc) begin
                nzp_q <= nzp_nxt;
            end
            if (ctrl_i.ld_ben) begin
                ben_q <= |(nzp_q & ir_q.off_form.nzp_dr);
            end
            if (ctrl_i.ld_led) begin
                led_q <= ir_q[11:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_i.ld_mar) begin
            mar_q <= bus;
        end
        if (ctrl_i.ld_mdr) begin
            mdr_q <= mdr_nxt;
        end
    end

    // Register file ports
    assign dr_addr_o  = (ctrl_i.dr_sel == DR_R7) ? 3'd7 : ir_q.reg_form.dr;
    assign sr1_addr_o = (ctrl_i.sr1_sel == SR1_DR) ? ir_q.reg_form.dr : ir_q.reg_form.sr1;
    assign sr2_addr_o = ir_q.reg_form.sr2;
    assign reg_wr_o   = ctrl_i.ld_reg;

    assign instr_o = ir_q;
    assign ben_o   = ben_q;
    assign bus_o   = bus;
    assign mar_o   = mar_q;
    assign mdr_o   = mdr_q;
    assign led_o   = led_q;

endmodule

//--- design/slc3_isa_pkg.sv
// Covers only the SLC-3 opcodes this core runs and any other opcode is skipped as a no-op
package slc3_isa_pkg;

    // ----------------------------------------
    // Data word
    // ----------------------------------------
    typedef logic [15:0] word_t;

    // Opcodes in scope, LC-3 encodings plus PAUSE in the spare slot
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ADD   = 4'b0001,
        OP_JSR   = 4'b0100,
        OP_AND   = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_NOT   = 4'b1001,
        OP_JMP   = 4'b1100,
        OP_PAUSE = 4'b1101
    } opcode_e;

    // ----------------------------------------
    // Instruction formats
    // ----------------------------------------

    // ADD, AND, NOT view
    // With imm set, {unused, sr2} holds imm5
    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] dr;
        logic [2:0] sr1;
        logic       imm;
        logic [1:0] unused;
        logic [2:0] sr2;
    } reg_form_t;

    // BR, JMP, JSR, LDR, STR, PAUSE view
    // offset9 is {base, offset6} and offset11 adds nzp_dr[1:0] on top
    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] nzp_dr;
        logic [2:0] base;
        logic [5:0] offset6;
    } off_form_t;

    typedef union packed {
        reg_form_t reg_form;
        off_form_t off_form;
    } instr_u;

endpackage

//--- design/slc3_reg_file.sv
// Reads are combinational, so a write is seen by the reads only after the clock edge
`timescale 1ns/1ps

module slc3_reg_file (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                wr_i,
    input  logic [2:0]          dr_addr_i,
    input  logic [2:0]          sr1_addr_i,
    input  logic [2:0]          sr2_addr_i,
    input  slc3_isa_pkg::word_t wdata_i,
    output slc3_isa_pkg::word_t sr1_data_o,
    output slc3_isa_pkg::word_t sr2_data_o
);

    import slc3_isa_pkg::*;

    word_t regs_q [8];

    // R0 to R7, all cleared on reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 8; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i) begin
            regs_q[dr_addr_i] <= wdata_i;
        end
    end

    assign sr1_data_o = regs_q[sr1_addr_i];
    assign sr2_data_o = regs_q[sr2_addr_i];

endmodule

//--- files.f
design/slc3_isa_pkg.sv
design/slc3_ctrl_pkg.sv
design/slc3_reg_file.sv
design/slc3_datapath.sv
design/slc3_control.sv
design/slc3_cpu.sv
testbench/slc3_cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the SLC-3 testbench with Verilator and runs it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot change to the project directory"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ps -f files.f \
    --top-module slc3_cpu_tb -Mdir obj_dir -o slc3_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/slc3_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

//--- testbench/slc3_cpu_tb.sv
// Run from the project root with the program image starting at RESET_PC 0 and fitting in 256 words
`timescale 1ns/1ps

module slc3_cpu_tb;

    localparam int MAX_RECS     = 64;
    localparam int REC_WORDS    = 3 * MAX_RECS;
    localparam int RESET_CYCLES = 8;

    logic        clk;
    logic        reset_i;
    logic        run_i;
    logic        continue_i;
    logic [15:0] mem_rdata_i;
    logic [15:0] mem_addr_o;
    logic [15:0] mem_wdata_o;
    logic        mem_ena_o;
    logic        mem_wr_o;
    logic [11:0] led_o;
    logic [15:0] hex_display_o;

    logic [15:0] mem [256];
    logic [15:0] rec_words [REC_WORDS];
    logic [15:0] exp_st_addr [$];
    logic [15:0] exp_st_data [$];
    logic [15:0] exp_led [$];

    int          n_recs;
    int          st_idx;
    int          pause_idx;
    int          tests_run;
    int          tests_failed;
    logic        loaded;
    logic        read_pending;
    logic [7:0]  read_addr;
    logic [16:0] lfsr;
    logic [15:0] last_ir;

    slc3_cpu #(
        .RESET_PC (16'h0000)
    ) dut0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .run_i         (run_i),
        .continue_i    (continue_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_ena_o     (mem_ena_o),
        .mem_wr_o      (mem_wr_o),
        .led_o         (led_o),
        .hex_display_o (hex_display_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // 17-bit Fibonacci LFSR with taps 17 and 14
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic draw_wait_cycles(output int n);
        n = 0;
        for (int b = 0; b < 4; b++) begin
            lfsr = lfsr_next(lfsr);
            n = (n << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic report_result(input string name, input logic ok);
        tests_run++;
        if (ok) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED", name);
        end
    endtask

    // Kind 0 goes to memory and kinds 1 and 2 to the expected queues
    task automatic load_records();
        int          r;
        logic [15:0] kind;
        for (int i = 0; i < REC_WORDS; i++) begin
            rec_words[i] = 16'hFFFF;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = 16'hA500 + 16'(i);
        end
        $readmemh("testbench/slc3_patterns.mem", rec_words);
        r = 0;
        while (r < MAX_RECS && rec_words[3 * r] != 16'hFFFF) begin
            kind = rec_words[3 * r];
            case (kind)
                16'd0: mem[rec_words[3 * r + 1][7:0]] = rec_words[3 * r + 2];
                16'd1: begin
                    exp_st_addr.push_back(rec_words[3 * r + 1]);
                    exp_st_data.push_back(rec_words[3 * r + 2]);
                end
                16'd2: exp_led.push_back(rec_words[3 * r + 2]);
                default: begin
                    $display("Record %0d has an unknown kind %h", r, kind);
                    tests_failed++;
                end
            endcase
            r++;
        end
        n_recs = r;
    endtask

    task automatic compare_store(input logic [15:0] addr, input logic [15:0] data);
        logic  ok;
        string name;
        ok = 1'b1;
        name = $sformatf("store %0d", st_idx + 1);
        if (st_idx >= exp_st_addr.size()) begin
            $display("Store of %h to address %h came after the last expected store", data, addr);
            ok = 1'b0;
        end else begin
            if (addr != exp_st_addr[st_idx]) begin
                $display("CHECK FAILED at %0t ns: store address %h, expected %h",
                         $time, addr, exp_st_addr[st_idx]);
                ok = 1'b0;
            end
            if (data != exp_st_data[st_idx]) begin
                $display("CHECK FAILED at %0t ns: store data %h, expected %h",
                         $time, data, exp_st_data[st_idx]);
                ok = 1'b0;
            end
        end
        st_idx++;
        report_result(name, ok);
    endtask

    task automatic watch_reset_idle();
        logic ok;
        ok = 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (mem_ena_o || mem_wr_o) begin
                $display("CHECK FAILED at %0t ns: memory strobe while halted", $time);
                ok = 1'b0;
            end
            if (led_o != 12'h000 || hex_display_o != 16'h0000) begin
                $display("CHECK FAILED at %0t ns: led_o %h hex %h, expected zero",
                         $time, led_o, hex_display_o);
                ok = 1'b0;
            end
        end
        report_result("reset idle", ok);
    endtask

    // Entered on the DECODE cycle of a PAUSE and holds continue_i low for a random time
    task automatic handle_pause();
        int    wait_cycles;
        logic  ok;
        string name;
        ok = 1'b1;
        name = $sformatf("pause %0d", pause_idx + 1);
        draw_wait_cycles(wait_cycles);
        repeat (wait_cycles + 2) begin
            @(negedge clk);
            if (mem_ena_o) begin
                $display("CHECK FAILED at %0t ns: memory strobe at %h while paused",
                         $time, mem_addr_o);
                ok = 1'b0;
            end
        end
        if (pause_idx >= exp_led.size()) begin
            $display("A PAUSE ran that the pattern file does not expect");
            ok = 1'b0;
        end else if (led_o != exp_led[pause_idx][11:0]) begin
            $display("CHECK FAILED at %0t ns: led_o %h, expected %h",
                     $time, led_o, exp_led[pause_idx][11:0]);
            ok = 1'b0;
        end
        pause_idx++;
        continue_i = 1'b1;
        @(negedge clk);
        continue_i = 1'b0;
        report_result(name, ok);
    endtask

    // One cycle of the running program, a newly decoded PAUSE is served here
    task automatic advance_cycle();
        @(negedge clk);
        if (hex_display_o != last_ir && hex_display_o[15:12] == 4'hD) begin
            handle_pause();
        end
        last_ir = hex_display_o;
    endtask

    // ----------------------------------------
    // Memory model
    // ----------------------------------------

    // Read data shows up one cycle after the strobe and is held for that cycle only
    always @(negedge clk) begin
        if (read_pending) begin
            mem_rdata_i = mem[read_addr];
        end else begin
            mem_rdata_i = 16'hFFFF;
        end
        read_pending = 1'b0;
        if (!reset_i && mem_ena_o) begin
            if (mem_wr_o) begin
                mem[mem_addr_o[7:0]] = mem_wdata_o;
                compare_store(mem_addr_o, mem_wdata_o);
            end else begin
                read_pending = 1'b1;
                read_addr = mem_addr_o[7:0];
            end
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        reset_i      = 1'b1;
        run_i        = 1'b0;
        continue_i   = 1'b0;
        mem_rdata_i  = 16'hFFFF;
        st_idx       = 0;
        pause_idx    = 0;
        tests_run    = 0;
        tests_failed = 0;
        read_pending = 1'b0;
        read_addr    = 8'h00;
        lfsr         = 17'd83648;
        loaded       = 1'b0;

        load_records();
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        watch_reset_idle();

        run_i = 1'b1;
        @(negedge clk);
        run_i = 1'b0;

        last_ir = hex_display_o;
        while (st_idx < exp_st_addr.size() || pause_idx < exp_led.size()) begin
            advance_cycle();
        end

        // Program ends in a branch loop so any further store or PAUSE is an error
        repeat (40) begin
            advance_cycle();
        end

        $display("Tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog allows about 30 cycles per record
    initial begin
        int limit;
        wait (loaded);
        limit = n_recs * 30 + RESET_CYCLES;
        repeat (limit) @(posedge clk);
        $display("Timeout: the program did not complete within %0d cycles", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- testbench/slc3_patterns.mem
// Columns: kind addr value. Kind 0 is a program word, 1 an expected store in order,
// 2 the expected PAUSE led value with addr at the PAUSE word
0 0000 1DAF  0 0001 1D86
0 0002 1D86  0 0003 1D86  // R6 = 0x78, base of the store area
0 0004 1267  0 0005 147D
0 0006 1642  0 0007 7780
0 0008 5842  0 0009 7981
0 000A 5AFA  0 000B 7B82
0 000C 98FF  0 000D 7983
0 000E 6B83  0 000F 0801  // LDR back, BRn over the marker
0 0010 7184  0 0011 1B6C
0 0012 7B85  0 0013 0A01
0 0014 7386  0 0015 0401
0 0016 7387  0 0017 14A0
0 0018 0C01  0 0019 7588
0 001A 0201  0 001B 7589
0 001C 0001  0 001D 778A
0 001E 4806  0 001F 738B  // JSR to 0x25
0 0020 D5A5  0 0021 778C
0 0022 D0C3  0 0023 0FFF  // Final branch loop
0 0025 7F8D  0 0026 C1C0  // Subroutine stores R7, then JMP R7

1 0078 000B  1 0079 0004  1 007A 000A
1 007B FFF4  1 007D 0000  1 007E 0007
1 0080 0004  1 0082 000B  1 0085 001F
1 0083 0007  2 0020 05A5  1 0084 000B
2 0022 00C3
